// ==== common/scal_ctl_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface scal_ctl_if import scaler_pkg::*; ();

	byte_t     gate_sel;      // Channel feeding the gated scaler
	byte_t     gate_len;
	logic      prescale_en;
	reg_addr_e rd_word;       // Word being read
	count_t    rd_count;      // Latched count for rd_word

	modport regs_mp (
		output gate_sel, gate_len, prescale_en, rd_word,
		input  rd_count
	);

	modport cond_mp (
		input gate_sel, gate_len
	);

	modport bank_mp (
		input  prescale_en, rd_word,
		output rd_count
	);

endinterface

`default_nettype wire

// ==== common/scaler_pkg.sv ====
`default_nettype none

package scaler_pkg;

	////////////////////
	// Widths and defaults
	////////////////////

	localparam int OUTPUT_BITS       = 16;   // Reported count width
	localparam int DEF_NUM_CHAN      = 4;
	localparam int DEF_PRESCALE_BITS = 5;    // Divide by 32 when prescale is on

	typedef logic [OUTPUT_BITS-1:0] count_t;
	typedef logic [7:0]             byte_t;

	// Gate window length after reset
	localparam byte_t GATE_LEN_DEFAULT = 8'd100;

	////////////////////
	// Register map
	////////////////////

	// Word address, taken from adr_i[3:1]
	typedef enum logic [2:0] {
		REG_CHAN0    = 3'd0,
		REG_CHAN1    = 3'd1,
		REG_CHAN2    = 3'd2,
		REG_CHAN3    = 3'd3,
		REG_T1       = 3'd4,
		REG_GATED    = 3'd5,
		REG_GATE_SEL = 3'd6,
		REG_GATE_CTL = 3'd7    // Low byte gate length, high byte control
	} reg_addr_e;

endpackage

`default_nettype wire

// ==== design/scaler_block.sv ====
`timescale 1ns/1ps
`default_nettype none

module scaler_block import scaler_pkg::*; #(
	parameter int NUM_CHAN      = DEF_NUM_CHAN,
	parameter int PRESCALE_BITS = DEF_PRESCALE_BITS
) (
	input  wire                fclk_i,
	input  wire                rst_n_i,

	input  wire [NUM_CHAN-1:0] chan_i,
	input  wire                t1_i,
	input  wire                ext_gate_i,
	input  wire                pps_i,      // One cycle per second

	input  wire                cyc_i,
	input  wire                stb_i,
	input  wire                wr_i,
	input  wire [3:0]          adr_i,
	input  wire byte_t         dat_i,
	output logic               ack_o,
	output byte_t              dat_o
);

	logic [NUM_CHAN-1:0] chan_q;       // Channels after the input register
	logic                t1_pulse;
	logic                gated_pulse;

	scal_ctl_if ctl_if ();

	trigger_cond #(
		.NUM_CHAN (NUM_CHAN)
	) trigger_cond_i (
		.fclk_i        (fclk_i),
		.rst_n_i       (rst_n_i),
		.chan_i        (chan_i),
		.t1_i          (t1_i),
		.ext_gate_i    (ext_gate_i),
		.ctl           (ctl_if.cond_mp),
		.chan_o        (chan_q),
		.t1_pulse_o    (t1_pulse),
		.gated_pulse_o (gated_pulse)
	);

	scaler_bank #(
		.NUM_CHAN      (NUM_CHAN),
		.PRESCALE_BITS (PRESCALE_BITS)
	) scaler_bank_i (
		.fclk_i        (fclk_i),
		.rst_n_i       (rst_n_i),
		.pps_i         (pps_i),
		.chan_i        (chan_q),
		.t1_pulse_i    (t1_pulse),
		.gated_pulse_i (gated_pulse),
		.ctl           (ctl_if.bank_mp)
	);

	scaler_regs scaler_regs_i (
		.fclk_i  (fclk_i),
		.rst_n_i (rst_n_i),
		.cyc_i   (cyc_i),
		.stb_i   (stb_i),
		.wr_i    (wr_i),
		.adr_i   (adr_i),
		.dat_i   (dat_i),
		.ctl     (ctl_if.regs_mp),
		.ack_o   (ack_o),
		.dat_o   (dat_o)
	);

endmodule

`default_nettype wire

// ==== design/scaler_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module scaler_regs import scaler_pkg::*; (
	input  wire         fclk_i,
	input  wire         rst_n_i,
	input  wire         cyc_i,
	input  wire         stb_i,
	input  wire         wr_i,
	input  wire [3:0]   adr_i,      // Word in 3:1, high byte in 0
	input  wire byte_t  dat_i,
	scal_ctl_if.regs_mp ctl,
	output logic        ack_o,
	output byte_t       dat_o
);

	reg_addr_e word;
	logic      start;
	logic      ack_q;
	byte_t     gate_sel_q;
	byte_t     gate_len_q;
	byte_t     ctl_byte_q;   // Bit 0 set turns prescale off
	count_t    rd_q;

	assign word  = reg_addr_e'(adr_i[3:1]);
	assign start = cyc_i && stb_i && !ack_q;

	////////////////////
	// Ack
	////////////////////

	// High for one cycle, so a new start waits at least one more
	always_ff @(posedge fclk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			ack_q <= 1'b0;
		else
			ack_q <= start;
	end

	////////////////////
	// Control registers
	////////////////////

	always_ff @(posedge fclk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			gate_sel_q <= '0;
			gate_len_q <= GATE_LEN_DEFAULT;
			ctl_byte_q <= '0;
		end else if (start && wr_i) begin
			case (word)
				REG_GATE_SEL:
					if (!adr_i[0])
						gate_sel_q <= dat_i;
				REG_GATE_CTL:
					if (adr_i[0])
						ctl_byte_q <= dat_i;
					else
						gate_len_q <= dat_i;
				default: ;                       // Count words are read only
			endcase
		end
	end

	// Read word captured at the start cycle
	always_ff @(posedge fclk_i) begin
		if (start) begin
			case (word)
				REG_GATE_SEL: rd_q <= {8'h00, gate_sel_q};
				REG_GATE_CTL: rd_q <= {ctl_byte_q, gate_len_q};
				default:      rd_q <= ctl.rd_count;
			endcase
		end
	end

	assign ctl.gate_sel    = gate_sel_q;
	assign ctl.gate_len    = gate_len_q;
	assign ctl.prescale_en = ~ctl_byte_q[0];
	assign ctl.rd_word     = word;

	assign ack_o = ack_q;
	assign dat_o = adr_i[0] ? rd_q[15:8] : rd_q[7:0];   // Master holds adr_i until ack

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the scaler block testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module scaler_block_tb -Mdir "$BUILD_DIR" -f scaler_block.f
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

"./$BUILD_DIR/Vscaler_block_tb" 2>&1 | tee "$LOG"
status=${PIPESTATUS[0]}

if grep -qF '*** TEST FAILED ***' "$LOG"; then
	echo "Simulation reported a failure, see $LOG"
	exit 1
fi
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi
echo "Simulation passed"
exit 0

// ==== scaler_bank/scaler_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module scaler_bank import scaler_pkg::*; #(
	parameter int NUM_CHAN      = DEF_NUM_CHAN,
	parameter int PRESCALE_BITS = DEF_PRESCALE_BITS
) (
	input  wire                fclk_i,
	input  wire                rst_n_i,
	input  wire                pps_i,
	input  wire [NUM_CHAN-1:0] chan_i,
	input  wire                t1_pulse_i,
	input  wire                gated_pulse_i,
	scal_ctl_if.bank_mp        ctl
);

	localparam int NUM_SCAL = NUM_CHAN + 2;          // Channels, then T1, then gated
	localparam int CNT_BITS = OUTPUT_BITS + PRESCALE_BITS;
	localparam logic [CNT_BITS-1:0] MAX_CNT = CNT_BITS'((1 << OUTPUT_BITS) - 1);

	logic [NUM_SCAL-1:0] hit;
	count_t              lat_cnt [NUM_SCAL];

	assign hit = {gated_pulse_i, t1_pulse_i, chan_i};

	// Clamp a running count to the reported width
	function automatic count_t limit(input logic [CNT_BITS-1:0] val);
		return (val > MAX_CNT) ? '1 : val[OUTPUT_BITS-1:0];
	endfunction

	////////////////////
	// Counters and pps latch
	////////////////////

	for (genvar i = 0; i < NUM_SCAL; i++) begin : g_scal
		logic [CNT_BITS-1:0] run_cnt;
		logic [CNT_BITS-1:0] scaled;

		if (i < NUM_CHAN) begin : g_pre
			assign scaled = ctl.prescale_en ? (run_cnt >> PRESCALE_BITS) : run_cnt;
		end else begin : g_raw
			assign scaled = run_cnt;                 // T1 and gated are never prescaled
		end

		always_ff @(posedge fclk_i or negedge rst_n_i) begin
			if (!rst_n_i) begin
				run_cnt    <= '0;
				lat_cnt[i] <= '0;
			end else if (pps_i) begin
				run_cnt    <= '0;                    // This cycle's input is dropped
				lat_cnt[i] <= limit(scaled);
			end else if (hit[i] && run_cnt != '1) begin
				run_cnt <= run_cnt + 1'b1;           // Saturates at all ones
			end
		end
	end

	////////////////////
	// Read port
	////////////////////

	always_comb begin
		case (ctl.rd_word)
			REG_T1:
				ctl.rd_count = lat_cnt[NUM_CHAN];
			REG_GATED:
				ctl.rd_count = lat_cnt[NUM_CHAN+1];
			REG_GATE_SEL, REG_GATE_CTL:
				ctl.rd_count = '0;                   // Served from the register slave
			default:
				ctl.rd_count = (int'(ctl.rd_word) < NUM_CHAN) ? lat_cnt[ctl.rd_word] : '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== scaler_block.f ====
common/scaler_pkg.sv
common/scal_ctl_if.sv
trigger_cond/trigger_cond.sv
scaler_bank/scaler_bank.sv
design/scaler_regs.sv
design/scaler_block.sv
verification/scaler_block_props.sv
verification/scaler_block_tb.sv

// ==== trigger_cond/trigger_cond.sv ====
`timescale 1ns/1ps
`default_nettype none

module trigger_cond import scaler_pkg::*; #(
	parameter int NUM_CHAN = DEF_NUM_CHAN
) (
	input  wire                fclk_i,
	input  wire                rst_n_i,
	input  wire [NUM_CHAN-1:0] chan_i,
	input  wire                t1_i,
	input  wire                ext_gate_i,
	scal_ctl_if.cond_mp        ctl,
	output logic [NUM_CHAN-1:0] chan_o,
	output logic               t1_pulse_o,
	output logic               gated_pulse_o
);

	localparam int SEL_BITS = (NUM_CHAN > 1) ? $clog2(NUM_CHAN) : 1;

	logic  t1_q;
	logic  t1_q2;
	logic  gate_open;
	byte_t gate_cnt;
	logic  sel_chan;
	logic  gated_and;
	logic  gated_pipe;

	////////////////////
	// T1 edge and channel register
	////////////////////

	always_ff @(posedge fclk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			t1_q       <= 1'b0;
			t1_q2      <= 1'b0;
			t1_pulse_o <= 1'b0;
			chan_o     <= '0;
		end else begin
			t1_q       <= t1_i;
			t1_q2      <= t1_q;
			t1_pulse_o <= t1_q & ~t1_q2;   // Rising edge only
			chan_o     <= chan_i;
		end
	end

	////////////////////
	// Gate window
	////////////////////

	// A new ext_gate_i restarts the window
	always_ff @(posedge fclk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			gate_open <= 1'b0;
			gate_cnt  <= '0;
		end else if (ext_gate_i) begin
			gate_open <= 1'b1;
			gate_cnt  <= '0;
		end else if (gate_open) begin
			gate_cnt <= gate_cnt + 1'b1;
			if (gate_cnt == ctl.gate_len)
				gate_open <= 1'b0;
		end else begin
			gate_cnt <= '0;
		end
	end

	// Out of range select counts nothing
	assign sel_chan = (ctl.gate_sel < NUM_CHAN) && chan_i[ctl.gate_sel[SEL_BITS-1:0]];

	always_ff @(posedge fclk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			gated_and     <= 1'b0;
			gated_pipe    <= 1'b0;
			gated_pulse_o <= 1'b0;
		end else begin
			gated_and     <= gate_open & sel_chan;
			gated_pipe    <= gated_and;
			gated_pulse_o <= gated_pipe;     // 3 cycles behind chan_i
		end
	end

endmodule

`default_nettype wire

// ==== verification/scaler_block_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module scaler_block_props (
	input wire fclk_i,
	input wire rst_n_i,
	input wire cyc_i,
	input wire stb_i,
	input wire ack_i
);

	////////////////////
	// Bus handshake
	////////////////////

	ack_single: assert property (@(posedge fclk_i) disable iff (!rst_n_i)
		ack_i |=> !ack_i)
		else $error("ack_o high for two cycles in a row");

	// Ack follows a start one cycle earlier
	ack_after_start: assert property (@(posedge fclk_i) disable iff (!rst_n_i)
		ack_i |-> $past(cyc_i && stb_i && !ack_i))
		else $error("ack_o high without a bus start");

	ack_in_reset: assert property (@(posedge fclk_i) !rst_n_i |-> !ack_i)
		else $error("ack_o high during reset");

endmodule

bind scaler_regs scaler_block_props scaler_block_props_i (
	.fclk_i  (fclk_i),
	.rst_n_i (rst_n_i),
	.cyc_i   (cyc_i),
	.stb_i   (stb_i),
	.ack_i   (ack_o)
);

`default_nettype wire

// ==== verification/scaler_block_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module scaler_block_tb import scaler_pkg::*; ();

	localparam int NUM_CHAN   = DEF_NUM_CHAN;
	localparam int NUM_ROWS   = 5;
	localparam int NUM_COUNTS = NUM_CHAN + 2;   // Channel words, T1, gated
	localparam int CLK_PERIOD = 4;
	localparam int ACK_WAIT   = 8;

	logic                fclk;
	logic                rst_n;
	logic [NUM_CHAN-1:0] chan;
	logic                t1;
	logic                ext_gate;
	logic                pps;
	logic                cyc;
	logic                stb;
	logic                wr;
	logic [3:0]          adr;
	byte_t               dat_w;
	logic                ack;
	byte_t               dat_r;

	int unsigned cycle_count = 0;
	int unsigned cycle_limit = 0;   // Zero until worked out from the table

	// Stimulus table, one entry per row
	int     row_pulses   [NUM_ROWS][NUM_CHAN];
	int     row_t1_edges [NUM_ROWS];
	int     row_t1_high  [NUM_ROWS];
	byte_t  row_ctl      [NUM_ROWS];
	byte_t  row_sel      [NUM_ROWS];
	byte_t  row_len      [NUM_ROWS];
	bit     row_hold     [NUM_ROWS];
	int     row_hold_len [NUM_ROWS];
	count_t row_exp      [NUM_ROWS][NUM_COUNTS];

	scaler_block #(
		.NUM_CHAN      (NUM_CHAN),
		.PRESCALE_BITS (DEF_PRESCALE_BITS)
	) scaler_block_i (
		.fclk_i     (fclk),
		.rst_n_i    (rst_n),
		.chan_i     (chan),
		.t1_i       (t1),
		.ext_gate_i (ext_gate),
		.pps_i      (pps),
		.cyc_i      (cyc),
		.stb_i      (stb),
		.wr_i       (wr),
		.adr_i      (adr),
		.dat_i      (dat_w),
		.ack_o      (ack),
		.dat_o      (dat_r)
	);

	initial begin
		fclk = 1'b0;
		forever #(CLK_PERIOD / 2) fclk = ~fclk;
	end

	always @(posedge fclk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit != 0 && cycle_count >= cycle_limit)
			stop_on_error($sformatf("Timeout, the run did not end within %0d cycles", cycle_limit));
	end

	////////////////////
	// Helpers
	////////////////////

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic set_row(input int r, input int p0, input int p1, input int p2, input int p3,
		input int t1_edges, input int t1_high, input int ctl_val, input int sel, input int len,
		input int hold, input int hold_len, input int e0, input int e1, input int e2,
		input int e3, input int e_t1, input int e_gated);
		row_pulses[r]   = '{p0, p1, p2, p3};
		row_t1_edges[r] = t1_edges;
		row_t1_high[r]  = t1_high;
		row_ctl[r]      = byte_t'(ctl_val);
		row_sel[r]      = byte_t'(sel);
		row_len[r]      = byte_t'(len);
		row_hold[r]     = (hold != 0);
		row_hold_len[r] = hold_len;
		row_exp[r]      = '{count_t'(e0), count_t'(e1), count_t'(e2), count_t'(e3),
			count_t'(e_t1), count_t'(e_gated)};
	endtask

	// Cycles of pulse activity in one row, worst case spacing
	function automatic int row_cycles(input int r);
		int max_p;
		max_p = 0;
		for (int c = 0; c < NUM_CHAN; c++)
			if (row_pulses[r][c] > max_p)
				max_p = row_pulses[r][c];
		return max_p * 4 + row_t1_edges[r] * (row_t1_high[r] + 3) + row_hold_len[r];
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n) begin
			@(posedge fclk);
			#1;
		end
	endtask

	task automatic wait_ack();
		int n;
		n = 0;
		do begin
			wait_cycles(1);
			n++;
		end while (!ack && n < ACK_WAIT);
		if (!ack)
			stop_on_error("No ack from the bus slave after a bus request");
	endtask

	task automatic finish_transfer();
		cyc = 1'b0;
		stb = 1'b0;
		wr  = 1'b0;
		wait_cycles(1);   // Ack drops here
	endtask

	task automatic bus_write(input reg_addr_e word, input logic hi, input byte_t data);
		cyc   = 1'b1;
		stb   = 1'b1;
		wr    = 1'b1;
		adr   = {word, hi};
		dat_w = data;
		wait_ack();
		finish_transfer();
	endtask

	task automatic bus_read(input reg_addr_e word, input logic hi, output byte_t data);
		cyc = 1'b1;
		stb = 1'b1;
		wr  = 1'b0;
		adr = {word, hi};
		wait_ack();
		data = dat_r;   // Valid while ack is high
		finish_transfer();
	endtask

	task automatic read_word(input reg_addr_e word, output count_t value);
		byte_t lo;
		byte_t hi;
		bus_read(word, 1'b0, lo);
		bus_read(word, 1'b1, hi);
		value = {hi, lo};
	endtask

	task automatic check_count(input string name, input count_t got, input count_t exp);
		if (got !== exp)
			stop_on_error($sformatf("FAILED %s: got 0x%04h, expected 0x%04h", name, got, exp));
	endtask

	task automatic check_byte(input string name, input byte_t got, input byte_t exp);
		if (got !== exp)
			stop_on_error($sformatf("FAILED %s: got 0x%02h, expected 0x%02h", name, got, exp));
	endtask

	////////////////////
	// Trigger stimulus
	////////////////////

	task automatic give_pps();
		pps = 1'b1;
		wait_cycles(1);
		pps = 1'b0;
	endtask

	// Single cycle pulses on all channels at once, random gaps
	task automatic drive_pulses(input int r);
		logic [NUM_CHAN-1:0] bits;
		int                  max_p;
		max_p = 0;
		for (int c = 0; c < NUM_CHAN; c++)
			if (row_pulses[r][c] > max_p)
				max_p = row_pulses[r][c];
		for (int s = 0; s < max_p; s++) begin
			bits = '0;
			for (int c = 0; c < NUM_CHAN; c++)
				bits[c] = (s < row_pulses[r][c]);
			chan = bits;
			wait_cycles(1);
			chan = '0;
			wait_cycles(1 + int'($urandom % 3));
		end
	endtask

	task automatic drive_t1(input int r);
		for (int e = 0; e < row_t1_edges[r]; e++) begin
			t1 = 1'b1;
			wait_cycles(row_t1_high[r]);
			t1 = 1'b0;
			wait_cycles(1 + int'($urandom % 3));
		end
	endtask

	// Selected channel high around a one cycle gate
	task automatic hold_gate_channel(input int r);
		chan = NUM_CHAN'(1) << row_sel[r];
		wait_cycles(3);
		ext_gate = 1'b1;
		wait_cycles(1);
		ext_gate = 1'b0;
		wait_cycles(row_hold_len[r] - 4);
		chan = '0;
	endtask

	////////////////////
	// Test sequence
	////////////////////

	initial begin
		count_t value;
		byte_t  lo;
		byte_t  hi;
		int     limit;
		int     r;
		int     w;
		rst_n    = 1'b0;
		chan     = '0;
		t1       = 1'b0;
		ext_gate = 1'b0;
		pps      = 1'b0;
		cyc      = 1'b0;
		stb      = 1'b0;
		wr       = 1'b0;
		adr      = '0;
		dat_w    = '0;
		void'($urandom(68));

		//      row ch0 ch1 ch2 ch3  t1 hi  ctl  sel len hold hlen  expected ch0..3 t1 gated
		set_row(0,  3,  5,  1,  0,   4, 1,  1,   0,  100, 0,  0,    3,  5,  1,  0,  4,  0);
		set_row(1,  70, 32, 31, 100, 2, 3,  0,   1,  50,  0,  0,    2,  1,  0,  3,  2,  0);
		set_row(2,  0,  2,  0,  7,   3, 4,  1,   2,  10,  1,  30,   0,  2,  30, 7,  3,  11);
		set_row(3,  1,  0,  4,  0,   1, 2,  1,   1,  25,  1,  40,   1,  40, 4,  0,  1,  26);
		set_row(4,  64, 0,  0,  33,  0, 1,  0,   3,  5,   1,  30,   2,  0,  0,  1,  0,  6);

		limit = 0;
		for (r = 0; r < NUM_ROWS; r++)
			limit += row_cycles(r) + 200;
		cycle_limit = 2 * limit;

		repeat (3) @(posedge fclk);
		#1;
		rst_n = 1'b1;

		// Reset values
		bus_read(REG_GATE_CTL, 1'b0, lo);
		bus_read(REG_GATE_CTL, 1'b1, hi);
		check_byte("gate_len after reset", lo, 8'h64);
		check_byte("control byte after reset", hi, 8'h00);
		read_word(REG_GATE_SEL, value);
		check_count("gate_sel word after reset", value, 16'h0000);
		for (w = 0; w < NUM_COUNTS; w++) begin
			read_word(reg_addr_e'(3'(w)), value);
			check_count($sformatf("count word %0d after reset", w), value, 16'h0000);
		end

		for (r = 0; r < NUM_ROWS; r++) begin
			bus_write(REG_GATE_CTL, 1'b1, row_ctl[r]);
			bus_write(REG_GATE_SEL, 1'b0, row_sel[r]);
			bus_write(REG_GATE_CTL, 1'b0, row_len[r]);
			give_pps();                      // Start of the counting interval
			drive_pulses(r);
			drive_t1(r);
			if (row_hold[r])
				hold_gate_channel(r);
			wait_cycles(12);
			give_pps();
			for (w = 0; w < NUM_COUNTS; w++) begin
				read_word(reg_addr_e'(3'(w)), value);
				check_count($sformatf("row %0d count word %0d", r, w), value, row_exp[r][w]);
			end
			read_word(REG_GATE_SEL, value);
			check_count($sformatf("row %0d gate_sel word", r), value, {8'h00, row_sel[r]});
			bus_read(REG_GATE_CTL, 1'b0, lo);
			bus_read(REG_GATE_CTL, 1'b1, hi);
			check_byte($sformatf("row %0d gate_len", r), lo, row_len[r]);
			check_byte($sformatf("row %0d control byte", r), hi, row_ctl[r]);
		end

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire
